// File: logic/tx_bit_pkg.sv
// Shared widths, timing constants, FSM encoding and the queued config word for the TX bit path
package tx_bit_pkg;

    localparam int DATA_W         = 64;    // Stream and packet RAM word
    localparam int ADDR_W         = 10;    // Packet RAM address
    localparam int LEN_W          = 13;    // MPDU plus CRC length in words
    localparam int NUM_Q          = 4;
    localparam int QIDX_W         = 2;
    localparam int CFG_FIFO_DEPTH = 64;    // Entries per config queue
    localparam int CFG_PTR_W      = $clog2(CFG_FIFO_DEPTH);
    localparam int CLK_PER_US     = 10;    // Simulation clock rate
    localparam int CTS_FILL_WAIT  = 20 * CLK_PER_US;   // Let the IQ FIFO fill for 20 us
    localparam int SIFS_W         = 14;
    localparam int CTS_WORDS      = 4;
    localparam int START_STRETCH  = 6;     // Start pulse width in clocks
    localparam int TRY_DL         = 3;     // Try-complete holdoff stages

    // CTS signal field and frame control
    localparam logic [11:0] CTS_SIGNAL_LEN = 12'd14;
    localparam logic [1:0]  CTS_FC_TYPE    = 2'b01;    // Control frame
    localparam logic [3:0]  CTS_FC_SUBTYPE = 4'b1100;  // CTS

    typedef enum logic [2:0] {
        WAIT_TO_TRIG     = 3'd0,
        WAIT_CHANCE      = 3'd1,
        PREPARE_TX_FETCH = 3'd2,
        PREPARE_TX_JUDGE = 3'd3,
        DO_CTS_TOSELF    = 3'd4,
        WAIT_SIFS        = 3'd5,
        DO_TX            = 3'd6,
        WAIT_TX_COMP     = 3'd7
    } hi_state_t;

    // One queue entry, written as two software words, decoded as fields
    typedef union packed {
        struct packed {
            logic [31:0] cts_toself_config;
            logic [31:0] tx_config;
        } halves;
        struct packed {
            logic             use_cts_protect;        // Bit 63
            logic             use_cts_traffic_rate;
            logic [5:0]       spare_hi;
            logic [15:0]      cts_duration;           // NAV for the CTS
            logic [3:0]       cts_rate;
            logic [3:0]       rate;                   // Bits 35:32
            logic [1:0]       linux_prio;             // Bits 31:30
            logic [3:0]       spare_mid;
            logic [5:0]       bd_wr_idx;              // Bits 25:20
            logic [1:0]       spare_lo;
            logic [3:0]       retrans_limit;
            logic             need_ack;
            logic [LEN_W-1:0] len_mpdu_plus_crc;      // Bits 12:0
        } fields;
    } tx_cfg_u;

endpackage

// File: logic/tx_bit_ifs.sv
// Internal links of the TX bit path: controller to config queues and controller to frame writer
`timescale 1ns/1ps

interface cfg_q_if import tx_bit_pkg::*; ();
    logic [QIDX_W-1:0] rd_sel;     // Queue being served
    logic              rd_en;      // Pops head of rd_sel
    logic [NUM_Q-1:0]  empty;
    tx_cfg_u           rd_data;    // FWFT head of rd_sel

    modport ctl (
        output rd_sel, rd_en,
        input  empty, rd_data
    );
    modport queues (
        input  rd_sel, rd_en,
        output empty, rd_data
    );
endinterface

interface frame_wr_if import tx_bit_pkg::*; ();
    tx_cfg_u           cur_cfg;
    logic              cts_write;    // Kick off the four CTS words
    logic              data_start;   // Begin copying the stream
    logic [ADDR_W-1:0] wr_addr;      // Last address put on the RAM port

    modport ctl (
        output cur_cfg, cts_write, data_start,
        input  wr_addr
    );
    modport writer (
        input  cur_cfg, cts_write, data_start,
        output wr_addr
    );
endinterface

// File: logic/tx_cfg_queues.sv
// Four per-queue config FIFOs, loaded on recv_done falling and read out by the TX controller
`timescale 1ns/1ps

module tx_cfg_queues import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic [31:0]       tx_config,
    input  logic [31:0]       cts_toself_config,
    input  logic [QIDX_W-1:0] cfg_queue_sel,
    input  logic              recv_done,
    cfg_q_if.queues           q
);
    logic                              recv_d;
    logic [NUM_Q-1:0]                  wr_en;    // One-hot write strobe
    tx_cfg_u                           wr_data;
    logic [NUM_Q-1:0][CFG_PTR_W:0]     wr_ptr;   // Extra MSB tells full from empty
    logic [NUM_Q-1:0][CFG_PTR_W:0]     rd_ptr;
    logic [NUM_Q-1:0]                  empty;
    logic [NUM_Q-1:0]                  full;
    logic [NUM_Q-1:0]                  wr_ok;
    logic [NUM_Q-1:0]                  rd_ok;
    tx_cfg_u                           mem [NUM_Q][CFG_FIFO_DEPTH];

    // DMA done is the falling edge of recv_done
    always_ff @(posedge clk) begin
        if (!rstn) begin
            recv_d <= 1'b0;
            wr_en  <= '0;
        end else begin
            recv_d <= recv_done;
            wr_en  <= NUM_Q'(recv_d && !recv_done) << cfg_queue_sel;
        end
    end

    always_ff @(posedge clk) begin
        wr_data.halves.cts_toself_config <= cts_toself_config;
        wr_data.halves.tx_config         <= tx_config;
    end

    always_comb begin
        for (int i = 0; i < NUM_Q; i++) begin
            empty[i] = wr_ptr[i] == rd_ptr[i];
            full[i]  = (wr_ptr[i] ^ rd_ptr[i]) == {1'b1, {CFG_PTR_W{1'b0}}};
            wr_ok[i] = wr_en[i] && !full[i];     // Full queue drops the entry
            rd_ok[i] = q.rd_en && q.rd_sel == QIDX_W'(i) && !empty[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            for (int i = 0; i < NUM_Q; i++) begin
                if (wr_ok[i])
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                if (rd_ok[i])
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_Q; i++) begin
            if (wr_ok[i])
                mem[i][wr_ptr[i][CFG_PTR_W-1:0]] <= wr_data;
        end
    end

    assign q.empty   = empty;
    assign q.rd_data = mem[q.rd_sel][rd_ptr[q.rd_sel][CFG_PTR_W-1:0]];   // Head, no latency

endmodule

// File: logic/tx_high_ctl.sv
// TX controller FSM: queue arbitration, config fetch, CTS-to-self waits and the data phase
`timescale 1ns/1ps

module tx_high_ctl import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    cfg_q_if.ctl              q,
    frame_wr_if.ctl           fw,
    input  logic [NUM_Q-1:0]  high_tx_allowed,
    input  logic              tx_bb_is_ongoing,
    input  logic              ctl_idle,
    input  logic              try_recent,
    input  logic              tx_iq_fifo_empty,
    input  logic [SIFS_W-1:0] sifs_wait,
    input  logic              tx_end_from_acc,
    input  logic              tx_try_complete,
    output logic [QIDX_W-1:0] tx_queue_idx,
    output logic              high_trigger,
    output logic              cts_bb_ongoing,
    output logic              cts_rf_ongoing,
    output logic              need_ack,
    output logic [3:0]        retrans_limit,
    output logic [5:0]        bd_wr_idx,
    output logic [1:0]        linux_prio
);
    hi_state_t         state;
    tx_cfg_u           cur_cfg;
    logic [SIFS_W-1:0] wait_cnt;    // Shared by IQ-fill and SIFS waits
    logic [QIDX_W-1:0] pick;
    logic              can_trig;
    logic              fill_done;
    logic              sifs_done;

    // Lowest non-empty queue wins
    always_comb begin
        pick = '0;
        for (int i = NUM_Q - 1; i >= 0; i--) begin
            if (!q.empty[i])
                pick = QIDX_W'(i);
        end
    end

    assign can_trig  = (q.empty != '1) && !tx_bb_is_ongoing && ctl_idle && !try_recent;
    assign fill_done = wait_cnt == SIFS_W'(CTS_FILL_WAIT);
    assign sifs_done = wait_cnt == sifs_wait;

    assign q.rd_sel  = tx_queue_idx;
    assign q.rd_en   = state == PREPARE_TX_FETCH;   // Head is latched the same cycle
    assign fw.cur_cfg    = cur_cfg;
    assign fw.cts_write  = state == PREPARE_TX_JUDGE && cur_cfg.fields.use_cts_protect;
    assign fw.data_start = (state == PREPARE_TX_JUDGE && !cur_cfg.fields.use_cts_protect) ||
                           (state == WAIT_SIFS && sifs_done);
    assign need_ack      = cur_cfg.fields.need_ack;
    assign retrans_limit = cur_cfg.fields.retrans_limit;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= WAIT_TO_TRIG;
            cur_cfg        <= '0;
            tx_queue_idx   <= '0;
            wait_cnt       <= '0;
            high_trigger   <= 1'b0;
            cts_bb_ongoing <= 1'b0;
            cts_rf_ongoing <= 1'b0;
        end else begin
            high_trigger <= 1'b0;
            // Air busy once word 3 is out and until the IQ FIFO drains
            cts_bb_ongoing <= state == DO_CTS_TOSELF && !tx_iq_fifo_empty &&
                              fw.wr_addr == ADDR_W'(CTS_WORDS - 1);
            case (state)
                WAIT_TO_TRIG: begin
                    wait_cnt       <= '0;
                    cts_rf_ongoing <= 1'b0;
                    if (can_trig) begin
                        tx_queue_idx <= pick;
                        high_trigger <= 1'b1;
                        state        <= WAIT_CHANCE;
                    end
                end
                WAIT_CHANCE: begin
                    if (high_tx_allowed[tx_queue_idx])   // Backoff done for this queue
                        state <= PREPARE_TX_FETCH;
                end
                PREPARE_TX_FETCH: begin
                    cur_cfg <= q.rd_data;
                    state   <= PREPARE_TX_JUDGE;
                end
                PREPARE_TX_JUDGE: begin
                    wait_cnt <= '0;
                    state    <= cur_cfg.fields.use_cts_protect ? DO_CTS_TOSELF : DO_TX;
                end
                DO_CTS_TOSELF: begin
                    if (!fill_done) begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end else begin
                        cts_rf_ongoing <= 1'b1;
                        if (tx_iq_fifo_empty) begin   // CTS fully sent
                            wait_cnt <= '0;
                            state    <= WAIT_SIFS;
                        end
                    end
                end
                WAIT_SIFS: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (sifs_done)
                        state <= DO_TX;
                end
                DO_TX: begin
                    if (tx_end_from_acc) begin
                        cts_rf_ongoing <= 1'b0;
                        state          <= WAIT_TO_TRIG;
                    end
                end
            endcase
        end
    end

    // Report which buffer and priority the attempt belonged to
    always_ff @(posedge clk) begin
        if (!rstn) begin
            bd_wr_idx  <= '0;
            linux_prio <= '0;
        end else if (tx_try_complete) begin
            bd_wr_idx  <= cur_cfg.fields.bd_wr_idx;
            linux_prio <= cur_cfg.fields.linux_prio;
        end
    end

endmodule

// File: logic/tx_frame_writer.sv
// Packet RAM writer: emits the CTS-to-self words, then copies the payload stream word by word
`timescale 1ns/1ps

module tx_frame_writer import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    frame_wr_if.writer        fw,
    input  logic [47:0]       mac_addr,
    input  logic [DATA_W-1:0] data_in,
    input  logic              emptyn,
    output logic              ask_data,
    output logic              we,
    output logic [ADDR_W-1:0] addr,
    output logic [DATA_W-1:0] din
);
    logic [3:0]        cts_rate;
    logic              parity;
    logic [1:0]        cts_idx;     // Next CTS word, wraps back to 0 after word 3
    logic [1:0]        cts_sel;
    logic              cts_busy;
    logic              cts_go;
    logic              take;        // Stream word accepted this cycle
    logic [LEN_W-1:0]  wcnt;
    logic [DATA_W-1:0] cts_word;

    assign cts_rate = fw.cur_cfg.fields.use_cts_traffic_rate ? fw.cur_cfg.fields.rate
                                                             : fw.cur_cfg.fields.cts_rate;
    assign parity   = ^{cts_rate, CTS_SIGNAL_LEN};   // Even parity over rate and length
    assign cts_sel  = cts_idx;
    assign cts_go   = fw.cts_write || cts_busy;
    assign take     = ask_data && emptyn;

    always_comb begin
        case (cts_sel)
            2'd0:    cts_word = {32'h0, 14'd0, parity, CTS_SIGNAL_LEN, 1'b0, cts_rate};  // SIGNAL
            2'd2:    cts_word = {mac_addr[31:0], fw.cur_cfg.fields.cts_duration, 8'd0,
                                 CTS_FC_SUBTYPE, CTS_FC_TYPE, 2'd0};   // FC, duration, RA low
            2'd3:    cts_word = {48'h0, mac_addr[47:32]};             // RA high
            default: cts_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cts_busy <= 1'b0;
            cts_idx  <= '0;
            ask_data <= 1'b0;
            wcnt     <= '0;
            we       <= 1'b0;
            addr     <= '0;
        end else begin
            we <= cts_go || take;
            if (cts_go) begin
                addr     <= ADDR_W'(cts_sel);
                cts_idx  <= cts_sel + 2'd1;
                cts_busy <= cts_sel != 2'(CTS_WORDS - 1);
            end else if (take) begin
                addr <= wcnt[ADDR_W-1:0];
            end
            if (fw.data_start) begin
                ask_data <= 1'b1;
                wcnt     <= '0;
            end else if (take) begin
                wcnt <= wcnt + 1'b1;
                if (wcnt == fw.cur_cfg.fields.len_mpdu_plus_crc - 1'b1)
                    ask_data <= 1'b0;   // Last word taken
            end
        end
    end

    always_ff @(posedge clk) begin
        din <= cts_go ? cts_word : data_in;
    end

    assign fw.wr_addr = addr;

endmodule

// File: logic/tx_pkt_bram.sv
// Packet buffer RAM, written by the frame writer and read by the PHY one clock after the address
`timescale 1ns/1ps

module tx_pkt_bram import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] din,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);
    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        rd_data <= mem[rd_addr];   // Registered read port
    end

endmodule

// File: logic/tx_start_gen.sv
// PHY start pulse on the threshold word write, plus the try-complete holdoff for arbitration
`timescale 1ns/1ps

module tx_start_gen import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  logic [ADDR_W-1:0] num_dma_symbol_th,
    input  logic              auto_start_mode,
    input  logic              tx_try_complete,
    output logic              start,
    output logic              try_recent
);
    logic                     we_q;
    logic [ADDR_W-1:0]        addr_q;
    logic [START_STRETCH-1:0] stretch;   // Hit shifted along to widen it
    logic [TRY_DL-1:0]        try_dl;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            we_q    <= 1'b0;
            addr_q  <= '0;
            stretch <= '0;
            try_dl  <= '0;
        end else begin
            we_q    <= we;
            addr_q  <= addr;
            stretch <= {stretch[START_STRETCH-2:0],
                        we_q && addr_q == num_dma_symbol_th && num_dma_symbol_th != '0};
            try_dl  <= {try_dl[TRY_DL-2:0], tx_try_complete};
        end
    end

    assign start      = auto_start_mode && (|stretch);
    assign try_recent = tx_try_complete || (|try_dl);   // Hold off the next trigger

endmodule

// File: logic/tx_bit_intf.sv
// Top of the Wi-Fi MAC transmit bit interface, wiring queues, controller, writer, RAM and start
`timescale 1ns/1ps

module tx_bit_intf import tx_bit_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  logic [DATA_W-1:0] data_in,
    input  logic              emptyn,
    output logic              ask_data,
    output logic [QIDX_W-1:0] tx_queue_idx,
    output logic [1:0]        linux_prio,
    output logic [5:0]        bd_wr_idx,
    input  logic              auto_start_mode,
    input  logic [ADDR_W-1:0] num_dma_symbol_th,
    input  logic [31:0]       tx_config,
    input  logic [31:0]       cts_toself_config,
    input  logic [QIDX_W-1:0] cfg_queue_sel,
    input  logic              recv_done,
    output logic              start,
    input  logic              tx_iq_fifo_empty,
    input  logic [SIFS_W-1:0] sifs_wait,
    input  logic [47:0]       mac_addr,
    input  logic              tx_try_complete,
    input  logic              ctl_idle,
    input  logic [NUM_Q-1:0]  high_tx_allowed,
    input  logic              tx_bb_is_ongoing,
    output logic              need_ack,
    output logic [3:0]        retrans_limit,
    output logic              high_trigger,
    output logic              cts_bb_ongoing,
    output logic              cts_rf_ongoing,
    input  logic              tx_end_from_acc,
    input  logic [ADDR_W-1:0] bram_addr,
    output logic [DATA_W-1:0] bram_data
);
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] din;
    logic              try_recent;

    cfg_q_if    cq ();
    frame_wr_if fwi ();

    tx_cfg_queues u_queues (
        .clk, .rstn, .tx_config, .cts_toself_config, .cfg_queue_sel, .recv_done,
        .q (cq.queues)
    );

    tx_high_ctl u_ctl (
        .clk, .rstn,
        .q  (cq.ctl),
        .fw (fwi.ctl),
        .high_tx_allowed, .tx_bb_is_ongoing, .ctl_idle, .try_recent, .tx_iq_fifo_empty,
        .sifs_wait, .tx_end_from_acc, .tx_try_complete, .tx_queue_idx, .high_trigger,
        .cts_bb_ongoing, .cts_rf_ongoing, .need_ack, .retrans_limit, .bd_wr_idx, .linux_prio
    );

    tx_frame_writer u_writer (
        .clk, .rstn,
        .fw (fwi.writer),
        .mac_addr, .data_in, .emptyn, .ask_data, .we, .addr, .din
    );

    tx_pkt_bram u_bram (
        .clk, .we, .addr, .din,
        .rd_addr (bram_addr),
        .rd_data (bram_data)
    );

    tx_start_gen u_start (
        .clk, .rstn, .we, .addr, .num_dma_symbol_th, .auto_start_mode, .tx_try_complete,
        .start, .try_recent
    );

endmodule

// File: include/tb_tx_util.svh
// Testbench helpers included inside the testbench module: LFSR stimulus, error counts, timed waits
`ifndef TB_TX_UTIL_SVH
`define TB_TX_UTIL_SVH

    logic [31:0] lfsr_state   = 32'h7b03eb9f;
    int          value_errs   = 0;   // Wrong values seen
    int          timeout_errs = 0;   // Waits that ran out

    // Right-shifting Galois LFSR, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    // One LFSR step per bit taken, LSB first into the result
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // Level of a watched DUT output by name
    function automatic logic probe(input string name);
        case (name)
            "high_trigger":   return high_trigger;
            "ask_data":       return ask_data;
            "cts_rf_ongoing": return cts_rf_ongoing;
            default:          return 1'bx;   // Unknown name never matches
        endcase
    endfunction

    // Poll on falling edges until the output reaches level or limit runs out
    task automatic wait_level(input string name, input logic level, input int limit);
        int n;
        n = 0;
        while (probe(name) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (probe(name) !== level) begin
            timeout_errs++;
            $display("Timed out after %0d cycles waiting for %s to reach %0b", limit, name, level);
        end
    endtask

`endif

// File: tests/tb_tx_bit_intf.sv
// Testbench for the TX bit interface; queues a plain and a CTS packet and checks the whole flow
`timescale 1ns/1ps

module tb_tx_bit_intf import tx_bit_pkg::*; ();
    logic              clk = 1'b0;
    logic              rstn;
    logic [DATA_W-1:0] data_in = '0;
    logic              emptyn  = 1'b0;
    logic              ask_data, start, high_trigger, cts_bb_ongoing, cts_rf_ongoing, need_ack;
    logic              auto_start_mode, recv_done, tx_iq_fifo_empty, tx_try_complete;
    logic              ctl_idle, tx_bb_is_ongoing, tx_end_from_acc;
    logic [QIDX_W-1:0] tx_queue_idx, cfg_queue_sel;
    logic [1:0]        linux_prio;
    logic [5:0]        bd_wr_idx;
    logic [3:0]        retrans_limit;
    logic [ADDR_W-1:0] num_dma_symbol_th, bram_addr;
    logic [31:0]       tx_config, cts_toself_config;
    logic [SIFS_W-1:0] sifs_wait;
    logic [47:0]       mac_addr;
    logic [NUM_Q-1:0]  high_tx_allowed;
    logic [DATA_W-1:0] bram_data;

    logic [DATA_W-1:0] words [16];         // Payload of the packet in flight
    logic [63:0]       stall_pat = '0;     // emptyn pattern for the source
    logic              stream_on = 1'b0;
    int                widx = 0;           // Next word offered
    int                cyc = 0;
    int                th_cyc = 0;         // Cycle of the threshold write
    int                start_delay = 0;
    int                start_cycles = 0;
    logic              start_d = 1'b0;
    int                wide_trig_errs = 0;
    int                overlap_errs = 0;
    tx_cfg_u           cfg1;
    tx_cfg_u           cfg2;

    `include "tb_tx_util.svh"

    tx_bit_intf dut (.*);

    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    // Stream source, advances on every word the DUT will take at the next rising edge
    always @(negedge clk) begin : stream_src
        int k;
        if (!stream_on) begin
            k    = 0;
            widx = 0;
        end
        emptyn  = stream_on && stall_pat[k % 64];
        data_in = words[widx % 16];
        if (emptyn && ask_data)
            widx++;
        k++;
    end

    // Start width and its distance from the threshold write
    always @(negedge clk) begin
        if (dut.we && dut.addr == num_dma_symbol_th)
            th_cyc = cyc;
        if (start)
            start_cycles++;
        if (start && !start_d)
            start_delay = cyc - th_cyc;
        start_d = start;
    end

    assert property (@(posedge clk) disable iff (!rstn) high_trigger |=> !high_trigger)
        else begin
            wide_trig_errs++;
            $display("high_trigger stayed high for more than one cycle");
        end
    assert property (@(posedge clk) disable iff (!rstn) !(ask_data && cts_bb_ongoing))
        else begin
            overlap_errs++;
            $display("ask_data was raised while the CTS was still on the air");
        end

    // One config entry through recv_done falling
    task automatic push_cfg(input logic [QIDX_W-1:0] sel, input tx_cfg_u cfg);
        tx_config         = cfg.halves.tx_config;
        cts_toself_config = cfg.halves.cts_toself_config;
        cfg_queue_sel     = sel;
        recv_done         = 1'b1;
        @(negedge clk);
        recv_done = 1'b0;
        repeat (3) @(negedge clk);   // Entry lands and empty clears
    endtask

    task automatic read_ram(input int a, output logic [DATA_W-1:0] d);
        bram_addr = ADDR_W'(a);
        @(negedge clk);
        d = bram_data;
    endtask

    task automatic check_payload(input int len);
        logic [DATA_W-1:0] got;
        for (int i = 0; i < len; i++) begin
            read_ram(i, got);
            check_eq($sformatf("bram_data[%0d]", i), got, words[i]);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] got;
        int                base;
        int                t0;
        logic              par;
        rstn              = 1'b0;
        auto_start_mode   = 1'b1;
        num_dma_symbol_th = ADDR_W'(5);
        tx_config         = '0;
        cts_toself_config = '0;
        cfg_queue_sel     = '0;
        recv_done         = 1'b0;
        tx_iq_fifo_empty  = 1'b0;   // IQ FIFO busy until the CTS is out
        sifs_wait         = SIFS_W'(16);
        mac_addr          = 48'h02a1_5c3e_9d47;
        tx_try_complete   = 1'b0;
        ctl_idle          = 1'b0;   // Hold arbitration while loading
        high_tx_allowed   = '1;
        tx_bb_is_ongoing  = 1'b0;
        tx_end_from_acc   = 1'b0;
        bram_addr         = '0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_eq("ask_data", 64'(ask_data), 64'd0);
        check_eq("start", 64'(start), 64'd0);
        check_eq("high_trigger", 64'(high_trigger), 64'd0);
        check_eq("cts_bb_ongoing", 64'(cts_bb_ongoing), 64'd0);
        check_eq("cts_rf_ongoing", 64'(cts_rf_ongoing), 64'd0);

        cfg2 = rand_bits(64);
        cfg2.fields.len_mpdu_plus_crc    = LEN_W'(6);
        cfg2.fields.use_cts_protect      = 1'b1;
        cfg2.fields.use_cts_traffic_rate = 1'b0;
        cfg1 = rand_bits(64);
        cfg1.fields.len_mpdu_plus_crc = LEN_W'(12);
        cfg1.fields.use_cts_protect   = 1'b0;
        push_cfg(2'd2, cfg2);   // Loaded first, yet queue 1 must win
        push_cfg(2'd1, cfg1);
        for (int i = 0; i < 12; i++)
            words[i] = rand_bits(64);
        stall_pat = rand_bits(64);
        stream_on = 1'b1;
        ctl_idle  = 1'b1;
        wait_level("high_trigger", 1'b1, 20);
        check_eq("tx_queue_idx", 64'(tx_queue_idx), 64'd1);
        wait_level("ask_data", 1'b1, 20);
        wait_level("ask_data", 1'b0, 400);
        check_eq("words taken", 64'(widx), 64'd12);
        stream_on = 1'b0;
        repeat (3) @(negedge clk);   // Last write reaches the RAM
        check_payload(12);
        check_eq("start high cycles", 64'(start_cycles), 64'(START_STRETCH));
        check_eq("start delay", 64'(start_delay), 64'd2);

        tx_try_complete = 1'b1;
        @(negedge clk);
        tx_try_complete = 1'b0;
        check_eq("bd_wr_idx", 64'(bd_wr_idx), 64'(cfg1.fields.bd_wr_idx));
        check_eq("linux_prio", 64'(linux_prio), 64'(cfg1.fields.linux_prio));
        check_eq("need_ack", 64'(need_ack), 64'(cfg1.fields.need_ack));
        check_eq("retrans_limit", 64'(retrans_limit), 64'(cfg1.fields.retrans_limit));

        // Second packet with CTS-to-self and no auto start
        base            = start_cycles;
        auto_start_mode = 1'b0;
        for (int i = 0; i < 6; i++)
            words[i] = rand_bits(64);
        stall_pat       = rand_bits(64);
        stream_on       = 1'b1;
        tx_end_from_acc = 1'b1;
        @(negedge clk);
        tx_end_from_acc = 1'b0;
        wait_level("high_trigger", 1'b1, 20);
        check_eq("tx_queue_idx", 64'(tx_queue_idx), 64'd2);
        wait_level("cts_rf_ongoing", 1'b1, CTS_FILL_WAIT + 50);
        check_eq("cts_bb_ongoing", 64'(cts_bb_ongoing), 64'd1);
        check_eq("ask_data", 64'(ask_data), 64'd0);
        par = ^{cfg2.fields.cts_rate, 1'b0, 12'd14};   // Even over SIGNAL bits 0 to 16
        read_ram(0, got);
        check_eq("cts word 0", got, {46'd0, par, 12'd14, 1'b0, cfg2.fields.cts_rate});
        read_ram(2, got);
        check_eq("cts word 2", got, {mac_addr[31:0], cfg2.fields.cts_duration, 16'h00c4});
        read_ram(3, got);
        check_eq("cts word 3", got, {48'd0, mac_addr[47:32]});
        t0               = cyc;
        tx_iq_fifo_empty = 1'b1;   // CTS has drained
        wait_level("ask_data", 1'b1, int'(sifs_wait) + 20);
        assert (cyc - t0 > int'(sifs_wait)) else begin
            value_errs++;
            $display("ask_data rose %0d cycles after the IQ FIFO drained, before SIFS was over",
                     cyc - t0);
        end
        check_eq("cts_bb_ongoing", 64'(cts_bb_ongoing), 64'd0);
        wait_level("ask_data", 1'b0, 200);
        check_eq("words taken", 64'(widx), 64'd6);
        stream_on = 1'b0;
        repeat (3) @(negedge clk);
        check_payload(6);
        check_eq("start high cycles", 64'(start_cycles - base), 64'd0);
        check_eq("cts_rf_ongoing", 64'(cts_rf_ongoing), 64'd1);
        tx_end_from_acc = 1'b1;
        @(negedge clk);
        tx_end_from_acc = 1'b0;
        check_eq("cts_rf_ongoing", 64'(cts_rf_ongoing), 64'd0);

        $display("Errors: %0d value, %0d timeout, %0d assertion", value_errs, timeout_errs,
                 wide_trig_errs + overlap_errs);
        if (value_errs == 0 && timeout_errs == 0 && wide_trig_errs == 0 && overlap_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tx_bit_intf.f
+incdir+include
logic/tx_bit_pkg.sv
logic/tx_bit_ifs.sv
logic/tx_cfg_queues.sv
logic/tx_high_ctl.sv
logic/tx_frame_writer.sv
logic/tx_pkt_bram.sv
logic/tx_start_gen.sv
logic/tx_bit_intf.sv
tests/tb_tx_bit_intf.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_tx_bit_intf
RTL_TOP   := tx_bit_intf
FILELIST  := tx_bit_intf.f
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS
SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/tb_tx_util.svh

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD) $(LOG)
